//--- rtl/friet_cfg.svh
// Friet datapath configuration: widths, round schedule and opcode values
`ifndef FRIET_CFG_SVH
`define FRIET_CFG_SVH

// Datapath widths
`define FRIET_LIMB_W            128
`define FRIET_STATE_W           512
`define FRIET_PAD_W             130
`define FRIET_SIZE_W            5
`define FRIET_RC_W              5
`define FRIET_OP_W              3

// Permutation schedule, unroll must divide the round count
`define FRIET_NUM_ROUNDS        24
`define FRIET_ROUNDS_PER_CYCLE  1

// Opcodes
`define FRIET_OP_INIT           3'd0
`define FRIET_OP_ENC            3'd1
`define FRIET_OP_DEC            3'd2
`define FRIET_OP_SQUEEZE        3'd3
`define FRIET_OP_DIRECT         3'd4

`endif

//--- rtl/friet_pkg.sv
// Friet shared types: state views, opcode encoding and stage results
`include "friet_cfg.svh"

package friet_pkg;

    // Limb a sits in the low bits
    typedef struct packed {
        logic [`FRIET_LIMB_W-1:0] d;
        logic [`FRIET_LIMB_W-1:0] c;
        logic [`FRIET_LIMB_W-1:0] b;
        logic [`FRIET_LIMB_W-1:0] a;
    } friet_limbs_t;

    // Flat view for the padded span, limb view for the round and parity
    typedef union packed {
        logic [`FRIET_STATE_W-1:0] flat;
        friet_limbs_t              limb;
    } friet_state_u;

    typedef enum logic [`FRIET_OP_W-1:0] {
        op_init    = `FRIET_OP_INIT,
        op_enc     = `FRIET_OP_ENC,
        op_dec     = `FRIET_OP_DEC,
        op_squeeze = `FRIET_OP_SQUEEZE,
        op_direct  = `FRIET_OP_DIRECT
    } friet_op_e;

    // Absorb stage towards the permutation
    typedef struct packed {
        friet_state_u next_state;
        logic         permute;
        logic         clear;
    } friet_absorb_t;

    // Absorb stage towards the output register
    typedef struct packed {
        logic [`FRIET_LIMB_W-1:0] data;
        logic [`FRIET_SIZE_W-1:0] size;
        logic                     last;
        logic                     produce;
    } friet_out_t;

endpackage

//--- rtl/friet_absorb.sv
// Friet absorb stage: opcode decode, padding, masking and output candidate
`timescale 1ns/10ps
`include "friet_cfg.svh"

module friet_absorb import friet_pkg::*; (
    input  friet_op_e                oper,
    input  logic [`FRIET_LIMB_W-1:0] din,
    input  logic [`FRIET_SIZE_W-1:0] din_size,
    input  logic                     din_last,
    input  friet_state_u             state,
    output friet_absorb_t            absorbed,
    output friet_out_t               out_cand
);

    localparam int bytes_per_limb = `FRIET_LIMB_W / 8;

    logic                     is_init;
    logic                     is_enc;
    logic                     is_dec;
    logic                     is_squeeze;
    logic                     is_direct;
    logic                     pad_bit;
    logic [`FRIET_PAD_W-1:0]  pad;
    logic [`FRIET_LIMB_W-1:0] mask;
    logic [`FRIET_LIMB_W-1:0] din_xor_a;
    logic [`FRIET_LIMB_W-1:0] data;
    logic [`FRIET_PAD_W-1:0]  contrib;
    logic [`FRIET_LIMB_W-1:0] fold;
    friet_state_u             next_state;

    // Opcodes 5 to 7 match none of these and fall through as no-ops
    assign is_init    = (oper == op_init);
    assign is_enc     = (oper == op_enc);
    assign is_dec     = (oper == op_dec);
    assign is_squeeze = (oper == op_squeeze);
    assign is_direct  = (oper == op_direct);

    // Domain separation bit
    assign pad_bit = is_direct ? din_last :
                     (is_enc || is_dec) ? ~din_last : 1'b0;

    // Two padding bits right after the last valid byte
    always_comb begin
        pad = '0;
        if (din_size >= bytes_per_limb) begin
            pad[`FRIET_PAD_W-1 -: 2] = {1'b1, pad_bit};
        end else begin
            pad[{din_size[3:0], 3'b000} +: 2] = {1'b1, pad_bit};
        end
    end

    // Low min(size, 16) bytes are live
    always_comb begin
        for (int i = 0; i < bytes_per_limb; i++) begin
            mask[8*i +: 8] = {8{din_size > i}};
        end
    end

    assign din_xor_a = (din ^ state.limb.a) & mask;
    assign data      = is_dec ? din_xor_a : (din & mask);
    assign contrib   = {2'b00, data} ^ pad;

    // Same contribution folded onto one limb keeps a^b^c^d at zero
    assign fold = contrib[`FRIET_LIMB_W-1:0]
                ^ {{(`FRIET_LIMB_W-2){1'b0}}, contrib[`FRIET_PAD_W-1:`FRIET_LIMB_W]};

    always_comb begin
        next_state = state;
        next_state.flat[`FRIET_PAD_W-1:0] = state.flat[`FRIET_PAD_W-1:0] ^ contrib;
        next_state.limb.d = state.limb.d ^ fold;
    end

    assign absorbed.next_state = next_state;
    assign absorbed.permute    = is_enc | is_dec | is_squeeze | is_direct;
    assign absorbed.clear      = is_init;

    // Squeeze returns limb a as it was before the absorb
    assign out_cand.data    = is_squeeze ? state.limb.a : din_xor_a;
    assign out_cand.size    = is_squeeze ? `FRIET_SIZE_W'(bytes_per_limb) : din_size;
    assign out_cand.last    = din_last;
    assign out_cand.produce = is_enc | is_dec | is_squeeze;

endmodule

//--- rtl/friet_round.sv
// Friet round: one parity-preserving mixing round on the four limbs
`timescale 1ns/10ps
`include "friet_cfg.svh"

module friet_round import friet_pkg::*; (
    input  friet_state_u           state_in,
    input  logic [`FRIET_RC_W-1:0] rc,
    output friet_state_u           state_out
);

    logic [`FRIET_LIMB_W-1:0] rc_ext;
    logic [`FRIET_LIMB_W-1:0] a1;
    logic [`FRIET_LIMB_W-1:0] d1;
    logic [`FRIET_LIMB_W-1:0] n;
    logic [`FRIET_LIMB_W-1:0] a2;
    logic [`FRIET_LIMB_W-1:0] d2;
    logic [`FRIET_LIMB_W-1:0] b3;
    logic [`FRIET_LIMB_W-1:0] c3;

    // Round constant into a and d
    assign rc_ext = {{(`FRIET_LIMB_W-`FRIET_RC_W){1'b0}}, rc};
    assign a1 = state_in.limb.a ^ rc_ext;
    assign d1 = state_in.limb.d ^ rc_ext;

    // Nonlinear term, added twice so the parity holds
    assign n  = state_in.limb.b & state_in.limb.c;
    assign a2 = a1 ^ n;
    assign d2 = d1 ^ n;

    // Mix new a into b and c
    assign b3 = state_in.limb.b ^ a2;
    assign c3 = state_in.limb.c ^ a2;

    // Rotate every limb left by one
    assign state_out.limb.a = {a2[`FRIET_LIMB_W-2:0], a2[`FRIET_LIMB_W-1]};
    assign state_out.limb.b = {b3[`FRIET_LIMB_W-2:0], b3[`FRIET_LIMB_W-1]};
    assign state_out.limb.c = {c3[`FRIET_LIMB_W-2:0], c3[`FRIET_LIMB_W-1]};
    assign state_out.limb.d = {d2[`FRIET_LIMB_W-2:0], d2[`FRIET_LIMB_W-1]};

endmodule

//--- rtl/friet_permute.sv
// Friet permutation: state register with an iterative unrolled round chain
`timescale 1ns/10ps
`include "friet_cfg.svh"

module friet_permute import friet_pkg::*; (
    input  logic          clk,
    input  logic          arstn,
    input  logic          accept,
    input  friet_absorb_t absorbed,
    output friet_state_u  state,
    output logic          busy
);

    localparam int rpc = `FRIET_ROUNDS_PER_CYCLE;
    localparam logic [`FRIET_RC_W-1:0] rpc_step = `FRIET_RC_W'(rpc);
    localparam logic [`FRIET_RC_W-1:0] last_rc  = `FRIET_RC_W'(`FRIET_NUM_ROUNDS);

    friet_state_u           state_q;
    logic [`FRIET_RC_W-1:0] rc_q;
    logic [`FRIET_RC_W-1:0] base_rc;
    logic [`FRIET_RC_W-1:0] rc_next;
    friet_state_u           chain [0:rpc];

    // A new block starts at round 0 straight from the absorb stage
    always_comb begin
        if (accept) begin
            chain[0] = absorbed.next_state;
            base_rc  = '0;
        end else begin
            chain[0] = state_q;
            base_rc  = rc_q;
        end
    end

    for (genvar j = 0; j < rpc; j++) begin : g_round
        friet_round i_friet_round (
            .state_in  (chain[j]),
            .rc        (base_rc + `FRIET_RC_W'(j)),
            .state_out (chain[j+1])
        );
    end

    assign rc_next = base_rc + rpc_step;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state_q.flat <= '0;
            rc_q         <= '0;
            busy         <= 1'b0;
        end else if (accept) begin
            if (absorbed.clear) begin
                state_q.flat <= '0;
            end else if (absorbed.permute) begin
                state_q <= chain[rpc];
                rc_q    <= rc_next;
                busy    <= (rc_next != last_rc);
            end
        end else if (busy) begin
            // Next group of rounds, stop once the index reaches the round count
            state_q <= chain[rpc];
            rc_q    <= rc_next;
            busy    <= (rc_next != last_rc);
        end
    end

    assign state = state_q;

endmodule

//--- rtl/friet_output.sv
// Friet output stage: output register, handshakes and input acceptance
`timescale 1ns/10ps
`include "friet_cfg.svh"

module friet_output import friet_pkg::*; (
    input  logic                     clk,
    input  logic                     arstn,
    input  logic                     din_valid,
    input  logic                     busy,
    input  friet_out_t               out_cand,
    input  logic                     dout_ready,
    output logic                     din_ready,
    output logic                     accept,
    output logic [`FRIET_LIMB_W-1:0] dout,
    output logic [`FRIET_SIZE_W-1:0] dout_size,
    output logic                     dout_last,
    output logic                     dout_valid
);

    logic has_data_q;
    logic load;
    logic drain;

    // Pending output lets a new word in only when it leaves in the same edge
    always_comb begin
        if (busy) begin
            din_ready = 1'b0;
        end else if (has_data_q) begin
            din_ready = dout_ready;
        end else begin
            din_ready = 1'b1;
        end
    end

    assign accept = din_valid & din_ready;
    assign load   = accept & out_cand.produce;
    assign drain  = has_data_q & dout_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            has_data_q <= 1'b0;
        end else if (load) begin
            has_data_q <= 1'b1;
        end else if (drain) begin
            has_data_q <= 1'b0;
        end
    end

    // Output word held stable until taken
    always_ff @(posedge clk) begin
        if (load) begin
            dout      <= out_cand.data;
            dout_size <= out_cand.size;
            dout_last <= out_cand.last;
        end
    end

    assign dout_valid = has_data_q;

endmodule

//--- rtl/friet_fault_check.sv
// Friet fault check: limb parity fold with a sticky fault flag
`timescale 1ns/10ps
`include "friet_cfg.svh"

module friet_fault_check import friet_pkg::*; (
    input  logic         clk,
    input  logic         arstn,
    input  logic         accept,
    input  logic         clear,
    input  friet_state_u state,
    output logic         fault_detected
);

    logic [`FRIET_LIMB_W-1:0] parity;

    // Healthy state folds to zero
    assign parity = state.limb.a ^ state.limb.b ^ state.limb.c ^ state.limb.d;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            fault_detected <= 1'b0;
        end else if (accept && clear) begin
            fault_detected <= 1'b0;
        end else begin
            fault_detected <= fault_detected | (|parity);
        end
    end

endmodule

//--- rtl/friet_core.sv
// Friet core: absorb, permutation, output and fault stages wired together
`timescale 1ns/10ps
`include "friet_cfg.svh"

module friet_core import friet_pkg::*; (
    input  logic                     clk,
    input  logic                     arstn,
    input  logic [`FRIET_OP_W-1:0]   oper,
    input  logic [`FRIET_LIMB_W-1:0] din,
    input  logic [`FRIET_SIZE_W-1:0] din_size,
    input  logic                     din_last,
    input  logic                     din_valid,
    output logic                     din_ready,
    output logic [`FRIET_LIMB_W-1:0] dout,
    output logic [`FRIET_SIZE_W-1:0] dout_size,
    output logic                     dout_last,
    output logic                     dout_valid,
    input  logic                     dout_ready,
    output logic                     fault_detected
);

    friet_absorb_t absorbed;
    friet_out_t    out_cand;
    friet_state_u  state;
    logic          accept;
    logic          busy;

    friet_absorb i_friet_absorb (
        .oper     (friet_op_e'(oper)),
        .din      (din),
        .din_size (din_size),
        .din_last (din_last),
        .state    (state),
        .absorbed (absorbed),
        .out_cand (out_cand)
    );

    friet_permute i_friet_permute (
        .clk      (clk),
        .arstn    (arstn),
        .accept   (accept),
        .absorbed (absorbed),
        .state    (state),
        .busy     (busy)
    );

    friet_output i_friet_output (
        .clk        (clk),
        .arstn      (arstn),
        .din_valid  (din_valid),
        .busy       (busy),
        .out_cand   (out_cand),
        .dout_ready (dout_ready),
        .din_ready  (din_ready),
        .accept     (accept),
        .dout       (dout),
        .dout_size  (dout_size),
        .dout_last  (dout_last),
        .dout_valid (dout_valid)
    );

    friet_fault_check i_friet_fault_check (
        .clk            (clk),
        .arstn          (arstn),
        .accept         (accept),
        .clear          (absorbed.clear),
        .state          (state),
        .fault_detected (fault_detected)
    );

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock and reset: 10 ns clock, reset held low for five cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic arstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release away from both clock edges
    initial begin
        arstn = 1'b0;
        repeat (5) @(posedge clk);
        #2 arstn = 1'b1;
    end

endmodule

//--- verification/friet_model.svh
// Friet reference model for padding, absorb, rounds, permutation and random words
`ifndef FRIET_MODEL_SVH
`define FRIET_MODEL_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1103515245 + 32'd12345;
endfunction

// Low min(size, 16) bytes set
function automatic logic [127:0] byte_mask(input logic [4:0] size);
    logic [127:0] m;
    int           n;
    m = '0;
    n = int'(size);
    if (n > 16) begin
        n = 16;
    end
    for (int i = 0; i < n; i++) begin
        m[8*i +: 8] = 8'hff;
    end
    return m;
endfunction

// Data plus the two padding bits over the 130-bit span
function automatic logic [129:0] pad_contrib(input logic [127:0] data, input logic [4:0] size,
                                             input logic pb);
    logic [129:0] v;
    int           n;
    v = {2'b00, data};
    n = int'(size);
    if (n >= 16) begin
        n = 16;
    end
    v[8*n]     = v[8*n] ^ pb;
    v[8*n + 1] = v[8*n + 1] ^ 1'b1;
    return v;
endfunction

function automatic logic [511:0] absorb_block(input logic [511:0] s, input logic [2:0] op,
                                              input logic [127:0] d, input logic [4:0] size,
                                              input logic last);
    logic         pb;
    logic [127:0] data;
    logic [129:0] v;
    pb = 1'b0;
    if (op == `FRIET_OP_DIRECT) begin
        pb = last;
    end else if (op == `FRIET_OP_ENC || op == `FRIET_OP_DEC) begin
        pb = ~last;
    end
    data = d & byte_mask(size);
    if (op == `FRIET_OP_DEC) begin
        data = (d ^ s[127:0]) & byte_mask(size);
    end
    v = pad_contrib(data, size, pb);
    s[129:0]   = s[129:0] ^ v;
    // Limb d takes the same bits folded to 128
    s[511:384] = s[511:384] ^ v[127:0] ^ {126'd0, v[129:128]};
    return s;
endfunction

function automatic logic [511:0] round_step(input logic [511:0] s, input logic [4:0] r);
    logic [127:0] a;
    logic [127:0] b;
    logic [127:0] c;
    logic [127:0] d;
    logic [127:0] n;
    a = s[127:0] ^ {123'd0, r};
    b = s[255:128];
    c = s[383:256];
    d = s[511:384] ^ {123'd0, r};
    n = b & c;
    a = a ^ n;
    d = d ^ n;
    b = b ^ a;
    c = c ^ a;
    return {d[126:0], d[127], c[126:0], c[127], b[126:0], b[127], a[126:0], a[127]};
endfunction

function automatic logic [511:0] permute_state(input logic [511:0] s);
    for (int r = 0; r < `FRIET_NUM_ROUNDS; r++) begin
        s = round_step(s, 5'(r));
    end
    return s;
endfunction

`endif

//--- verification/tb_friet_core.sv
// Table-driven testbench of the Friet core against the reference model
`timescale 1ns/10ps
`include "friet_cfg.svh"

module tb_friet_core;

    localparam int wait_limit  = 100;
    localparam int busy_cycles = `FRIET_NUM_ROUNDS / `FRIET_ROUNDS_PER_CYCLE - 1;

    // One operation of the table
    typedef struct packed {
        logic [2:0]   oper;
        logic [127:0] din;
        logic [4:0]   size;
        logic         last;
        // Cycles with dout_ready held low
        logic [7:0]   hold;
        logic         exp_out;
        logic [127:0] exp_data;
        logic [4:0]   exp_size;
    } row_t;

    logic         clk;
    logic         arstn;
    logic [2:0]   oper;
    logic [127:0] din;
    logic [4:0]   din_size;
    logic         din_last;
    logic         din_valid;
    logic         din_ready;
    logic [127:0] dout;
    logic [4:0]   dout_size;
    logic         dout_last;
    logic         dout_valid;
    logic         dout_ready;
    logic         fault_detected;

    row_t         rows [$];
    logic [511:0] model_state;
    logic [31:0]  seed;

    `include "friet_model.svh"

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .arstn (arstn)
    );

    friet_core i_friet_core (
        .clk            (clk),
        .arstn          (arstn),
        .oper           (oper),
        .din            (din),
        .din_size       (din_size),
        .din_last       (din_last),
        .din_valid      (din_valid),
        .din_ready      (din_ready),
        .dout           (dout),
        .dout_size      (dout_size),
        .dout_last      (dout_last),
        .dout_valid     (dout_valid),
        .dout_ready     (dout_ready),
        .fault_detected (fault_detected)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [127:0] rand_word();
        logic [127:0] w;
        for (int i = 0; i < 4; i++) begin
            seed = lcg_next(seed);
            w[32*i +: 32] = seed;
        end
        return w;
    endfunction

    // Expected response from the model before the model state moves on
    function automatic row_t make_row(input logic [2:0] op, input logic [127:0] d,
                                      input logic [4:0] size, input logic last,
                                      input logic [7:0] hold);
        row_t r;
        r.oper     = op;
        r.din      = d;
        r.size     = size;
        r.last     = last;
        r.hold     = hold;
        r.exp_out  = (op == `FRIET_OP_ENC) || (op == `FRIET_OP_DEC) || (op == `FRIET_OP_SQUEEZE);
        r.exp_data = (op == `FRIET_OP_SQUEEZE) ? model_state[127:0]
                                               : (d ^ model_state[127:0]) & byte_mask(size);
        r.exp_size = (op == `FRIET_OP_SQUEEZE) ? 5'd16 : size;
        if (op == `FRIET_OP_INIT) begin
            model_state = '0;
        end else if (op >= `FRIET_OP_ENC && op <= `FRIET_OP_DIRECT) begin
            model_state = permute_state(absorb_block(model_state, op, d, size, last));
        end
        return r;
    endfunction

    task automatic build_table();
        logic [127:0] plain [4];
        logic [127:0] cipher [4];
        logic [4:0]   sizes [4];
        logic [127:0] enc_squeeze;
        row_t         r;
        sizes = '{5'd0, 5'd5, 5'd16, 5'd20};
        model_state = '0;
        rows.push_back(make_row(`FRIET_OP_INIT, '0, 5'd0, 1'b0, 8'd0));
        for (int i = 0; i < 4; i++) begin
            plain[i] = rand_word();
            r = make_row(`FRIET_OP_ENC, plain[i], sizes[i], i == 3, 8'd0);
            cipher[i] = r.exp_data;
            rows.push_back(r);
        end
        // Long hold reaches past the busy period
        r = make_row(`FRIET_OP_SQUEEZE, '0, 5'd0, 1'b1, 8'd30);
        enc_squeeze = r.exp_data;
        rows.push_back(r);
        rows.push_back(make_row(`FRIET_OP_INIT, '0, 5'd0, 1'b0, 8'd0));
        for (int i = 0; i < 4; i++) begin
            r = make_row(`FRIET_OP_DEC, cipher[i], sizes[i], i == 3, 8'd0);
            // Decrypt must give the plaintext back
            r.exp_data = plain[i] & byte_mask(sizes[i]);
            rows.push_back(r);
        end
        // Decrypt absorbs the same plaintext and repeats the encrypt squeeze
        r = make_row(`FRIET_OP_SQUEEZE, '0, 5'd0, 1'b1, 8'd0);
        r.exp_data = enc_squeeze;
        rows.push_back(r);
        rows.push_back(make_row(`FRIET_OP_INIT, '0, 5'd0, 1'b0, 8'd0));
        rows.push_back(make_row(`FRIET_OP_DIRECT, rand_word(), 5'd7, 1'b0, 8'd0));
        rows.push_back(make_row(`FRIET_OP_DIRECT, rand_word(), 5'd16, 1'b1, 8'd0));
        rows.push_back(make_row(`FRIET_OP_SQUEEZE, rand_word(), 5'd3, 1'b0, 8'd4));
    endtask

    task automatic apply_row(input row_t row);
        int waited;
        int low_cycles;
        int exp_busy;
        exp_busy = (row.oper >= `FRIET_OP_ENC && row.oper <= `FRIET_OP_DIRECT) ? busy_cycles : 0;
        @(negedge clk);
        oper       = row.oper;
        din        = row.din;
        din_size   = row.size;
        din_last   = row.last;
        din_valid  = 1'b1;
        dout_ready = (row.hold == 8'd0);
        waited     = 0;
        #1;
        while (!din_ready) begin
            if (waited == wait_limit) begin
                fail_run("Timeout waiting for din_ready before a new word");
            end
            waited++;
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        din_valid = 1'b0;
        check_value("dout_valid", 128'(dout_valid), 128'(row.exp_out));
        if (row.exp_out) begin
            check_value("dout", dout, row.exp_data);
            check_value("dout_size", 128'(dout_size), 128'(row.exp_size));
            check_value("dout_last", 128'(dout_last), 128'(row.last));
        end
        for (int k = 0; k < int'(row.hold); k++) begin
            @(negedge clk);
            check_value("dout_valid", 128'(dout_valid), 128'd1);
            check_value("dout", dout, row.exp_data);
            check_value("din_ready", 128'(din_ready), 128'd0);
        end
        if (row.hold != 8'd0) begin
            dout_ready = 1'b1;
        end else begin
            low_cycles = 0;
            while (!din_ready) begin
                if (low_cycles == wait_limit) begin
                    fail_run("Timeout waiting for the permutation to finish");
                end
                low_cycles++;
                @(negedge clk);
            end
            check_value("busy cycles", 128'(low_cycles), 128'(exp_busy));
        end
        check_value("fault_detected", 128'(fault_detected), 128'd0);
    endtask

    initial begin
        int waited;
        oper       = '0;
        din        = '0;
        din_size   = '0;
        din_last   = 1'b0;
        din_valid  = 1'b0;
        dout_ready = 1'b1;
        seed       = 32'h64ad;
        build_table();
        waited = 0;
        while (arstn !== 1'b1) begin
            if (waited == wait_limit) begin
                fail_run("Reset was never released");
            end
            waited++;
            @(negedge clk);
        end
        @(negedge clk);
        check_value("din_ready", 128'(din_ready), 128'd1);
        check_value("dout_valid", 128'(dout_valid), 128'd0);
        check_value("fault_detected", 128'(fault_detected), 128'd0);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- all.f
+incdir+rtl
+incdir+verification
rtl/friet_pkg.sv
rtl/friet_absorb.sv
rtl/friet_round.sv
rtl/friet_permute.sv
rtl/friet_output.sv
rtl/friet_fault_check.sv
rtl/friet_core.sv
verification/tb_clock_gen.sv
verification/tb_friet_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the Friet core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f all.f \
    --top-module tb_friet_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_friet_core > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
